// ==== Makefile ====
# Verilator flow for the FP multiply operand-preparation stage.
# Every variable below can be overridden on the command line,
# e.g. make sim OBJ_DIR=build LOG=run.log

VERILATOR  ?= verilator
TOP        ?= fpPrepTb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test passed
LINT_FLAGS ?= -Wall
BUILD_FLAGS ?= -j 0
SIM_ARGS   ?=

COMMON_FLAGS = --timing --assert -f $(FILELIST) --top-module $(TOP)
SOURCES      = $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
BINARY       = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(COMMON_FLAGS)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(BUILD_FLAGS) $(COMMON_FLAGS) -Mdir $(OBJ_DIR)

# the run passes only if the log holds the pass line
sim: $(BINARY)
	./$(BINARY) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass line not found in $(LOG)"; exit 1; }
	@echo "PASS: see $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/fpPrepRef.svh ====
`ifndef FP_PREP_REF_SVH
`define FP_PREP_REF_SVH

typedef expSum_t  [LANES-1:0] expLanes_t;
typedef manTile_t [LANES-1:0] tileLanes_t;

// A side pairs its hi tile with lanes 0 and 1, B side with lanes 0 and 2
function automatic bit usesHiTile(input int lane, input bit sideB);
    int pos;
    pos = lane % 4;
    if (sideB) begin
        return (pos == 0) || (pos == 2);
    end
    return pos < 2;
endfunction

// one operand's fields as seen by one lane
function automatic void laneFields(input logic [OPERAND_W-1:0] word,
                                   input precMode_t mode,
                                   input int lane,
                                   input bit sideB,
                                   output logic sgn,
                                   output expField_t ex,
                                   output logic zr,
                                   output manTile_t tile);
    logic [15:0] half;
    logic [31:0] single;
    half   = word[lane*16 +: 16];
    single = word[(lane/4)*32 +: 32];  // only words 0..3 feed fp32
    sgn    = 1'b0;
    ex     = '0;
    zr     = 1'b1;                      // off and reserved
    tile   = '0;
    if (mode == MODE_FP16) begin
        sgn  = half[15];
        ex   = {3'b000, half[14:10]};
        zr   = (half[14:0] == '0);
        tile = {2'b00, (half[14:10] != '0), half[9:0]};
    end else if (mode == MODE_FP32) begin
        sgn = single[31];
        ex  = single[30:23];
        zr  = (single[30:0] == '0);
        if (usesHiTile(lane, sideB)) begin
            tile = {2'b00, (single[30:23] != '0), single[22:13]};
        end else begin
            tile = single[12:0];
        end
    end
endfunction

function automatic logic [LANES-1:0] refSign(input logic [OPERAND_W-1:0] a,
                                              input logic [OPERAND_W-1:0] b,
                                              input precMode_t mode);
    logic [LANES-1:0] res;
    logic      signA;
    logic      signB;
    logic      zeroA;
    logic      zeroB;
    expField_t expA;
    expField_t expB;
    manTile_t  tileA;
    manTile_t  tileB;
    for (int lane = 0; lane < LANES; lane++) begin
        laneFields(a, mode, lane, 1'b0, signA, expA, zeroA, tileA);
        laneFields(b, mode, lane, 1'b1, signB, expB, zeroB, tileB);
        res[lane] = (zeroA || zeroB) ? 1'b0 : (signA ^ signB);
    end
    return res;
endfunction

// exponent sum, each hi tile adds 13 to the product weight in fp32
function automatic expLanes_t refExp(input logic [OPERAND_W-1:0] a,
                                     input logic [OPERAND_W-1:0] b,
                                     input precMode_t mode);
    expLanes_t res;
    logic      signA;
    logic      signB;
    logic      zeroA;
    logic      zeroB;
    expField_t expA;
    expField_t expB;
    manTile_t  tileA;
    manTile_t  tileB;
    int        weight;
    for (int lane = 0; lane < LANES; lane++) begin
        laneFields(a, mode, lane, 1'b0, signA, expA, zeroA, tileA);
        laneFields(b, mode, lane, 1'b1, signB, expB, zeroB, tileB);
        weight = 0;
        if (mode == MODE_FP32) begin
            weight += usesHiTile(lane, 1'b0) ? 13 : 0;
            weight += usesHiTile(lane, 1'b1) ? 13 : 0;
        end
        if (zeroA || zeroB) begin
            res[lane] = '0;
        end else begin
            res[lane] = {2'b00, expA} + {2'b00, expB} + 10'(weight);
        end
    end
    return res;
endfunction

function automatic tileLanes_t refTiles(input logic [OPERAND_W-1:0] word,
                                        input precMode_t mode,
                                        input bit sideB);
    tileLanes_t res;
    logic       sgn;
    logic       zr;
    expField_t  ex;
    for (int lane = 0; lane < LANES; lane++) begin
        laneFields(word, mode, lane, sideB, sgn, ex, zr, res[lane]);
    end
    return res;
endfunction

`endif

// ==== dv/fpPrepTb.sv ====
`default_nettype none

module fpPrepTb;
    timeunit 1ns;
    timeprecision 100ps;

    import fpPrepPkg::*;

    `include "fpPrepRef.svh"

    localparam int SEED           = 62;
    localparam int RESET_CYCLES   = 4;
    localparam int PHASE_LEN      = 200;   // cycles per stimulus phase
    localparam int TIMEOUT_CYCLES = 1500;  // reset plus six phases plus margin

    logic                 clk;
    logic                 rstn;
    logic [OPERAND_W-1:0] i_a;
    logic [OPERAND_W-1:0] i_b;
    precMode_t            i_mode;
    logic [LANES-1:0]     o_sign;
    expLanes_t            o_exp;
    tileLanes_t           o_manA;
    tileLanes_t           o_manB;
    precMode_t            o_mode;

    logic [OPERAND_W-1:0] prevA;            // inputs captured on the last edge
    logic [OPERAND_W-1:0] prevB;
    precMode_t            prevMode;
    logic                 checkOn = 1'b0;   // high once out of reset for a full cycle
    logic [LANES-1:0]     expSign;
    expLanes_t            expExp;
    tileLanes_t           expManA;
    tileLanes_t           expManB;
    int                   cycleCount    = 0;
    int                   checkedCycles = 0;
    int                   errorCount    = 0;

    fpMulPrepTop dut (
        .clk    (clk),
        .rstn   (rstn),
        .i_a    (i_a),
        .i_b    (i_b),
        .i_mode (i_mode),
        .o_sign (o_sign),
        .o_exp  (o_exp),
        .o_manA (o_manA),
        .o_manB (o_manB),
        .o_mode (o_mode)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        prevA    <= i_a;
        prevB    <= i_b;
        prevMode <= i_mode;
        checkOn  <= rstn;
    end

    always_comb expSign = refSign(prevA, prevB, prevMode);
    always_comb expExp  = refExp(prevA, prevB, prevMode);
    always_comb expManA = refTiles(prevA, prevMode, 1'b0);
    always_comb expManB = refTiles(prevB, prevMode, 1'b1);

    // covers reset held and the first edge after release
    resetValues: assert property (@(posedge clk) (cycleCount > 0 && !checkOn) |->
            (o_sign == '0 && o_exp == '0 && o_manA == '0 && o_manB == '0 &&
             o_mode == MODE_OFF))
        else begin
            errorCount++;
            $display("** Error: outputs not in reset state at cycle %0d, o_sign=%h o_exp=%h",
                     $sampled(cycleCount), $sampled(o_sign), $sampled(o_exp));
            $display("** Error: reset state o_manA=%h o_manB=%h o_mode=%h",
                     $sampled(o_manA), $sampled(o_manB), $sampled(o_mode));
        end

    signCheck: assert property (@(posedge clk) checkOn |-> (o_sign == expSign))
        else begin
            errorCount++;
            $display("** Error: o_sign at cycle %0d expected %h actual %h",
                     $sampled(cycleCount), $sampled(expSign), $sampled(o_sign));
        end

    expCheck: assert property (@(posedge clk) checkOn |-> (o_exp == expExp))
        else begin
            errorCount++;
            $display("** Error: o_exp at cycle %0d expected %h actual %h",
                     $sampled(cycleCount), $sampled(expExp), $sampled(o_exp));
        end

    manACheck: assert property (@(posedge clk) checkOn |-> (o_manA == expManA))
        else begin
            errorCount++;
            $display("** Error: o_manA at cycle %0d expected %h actual %h",
                     $sampled(cycleCount), $sampled(expManA), $sampled(o_manA));
        end

    manBCheck: assert property (@(posedge clk) checkOn |-> (o_manB == expManB))
        else begin
            errorCount++;
            $display("** Error: o_manB at cycle %0d expected %h actual %h",
                     $sampled(cycleCount), $sampled(expManB), $sampled(o_manB));
        end

    modeCheck: assert property (@(posedge clk) checkOn |-> (o_mode == prevMode))
        else begin
            errorCount++;
            $display("** Error: o_mode at cycle %0d expected %h actual %h",
                     $sampled(cycleCount), $sampled(prevMode), $sampled(o_mode));
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (checkOn) begin
            checkedCycles <= checkedCycles + 1;
        end
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [OPERAND_W-1:0] randomWord();
        logic [OPERAND_W-1:0] w;
        for (int k = 0; k < OPERAND_W / 32; k++) begin
            w[k*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    function automatic precMode_t randomMode();
        case ($urandom_range(3))
            0: return MODE_FP16;
            1: return MODE_FP32;
            2: return MODE_RSVD;
            default: return MODE_OFF;
        endcase
    endfunction

    function automatic precMode_t idleMode();
        return ($urandom_range(1) == 0) ? MODE_OFF : MODE_RSVD;
    endfunction

    // exact zeros in some lanes, subnormals (exponent only cleared) in others
    function automatic logic [OPERAND_W-1:0] zeroLanes(input logic [OPERAND_W-1:0] word,
                                                       input precMode_t mode);
        logic [OPERAND_W-1:0] w;
        int unsigned          pick;
        w = word;
        if (mode == MODE_FP32) begin
            for (int g = 0; g < LANES / GROUP_LANES; g++) begin
                pick = $urandom_range(3);
                if (pick == 0) begin
                    w[g*32 +: 31] = '0;
                end else if (pick == 1) begin
                    w[g*32+23 +: 8] = '0;
                end
            end
        end else begin
            for (int lane = 0; lane < LANES; lane++) begin
                pick = $urandom_range(3);
                if (pick == 0) begin
                    w[lane*16 +: 15] = '0;
                end else if (pick == 1) begin
                    w[lane*16+10 +: 5] = '0;
                end
            end
        end
        return w;
    endfunction

    task automatic driveCycle(input logic [OPERAND_W-1:0] a,
                              input logic [OPERAND_W-1:0] b,
                              input precMode_t mode);
        @(posedge clk);
        #5;
        i_a    = a;
        i_b    = b;
        i_mode = mode;
    endtask

    initial begin
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        precMode_t            mode;
        void'($urandom(SEED));
        clk    = 1'b0;
        rstn   = 1'b0;
        i_a    = '0;
        i_b    = '0;
        i_mode = MODE_OFF;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rstn = 1'b1;

        repeat (PHASE_LEN) driveCycle(randomWord(), randomWord(), MODE_FP16);
        repeat (PHASE_LEN) driveCycle(randomWord(), randomWord(), MODE_FP32);
        repeat (PHASE_LEN) begin
            driveCycle(zeroLanes(randomWord(), MODE_FP16),
                       zeroLanes(randomWord(), MODE_FP16), MODE_FP16);
        end
        repeat (PHASE_LEN) begin
            driveCycle(zeroLanes(randomWord(), MODE_FP32),
                       zeroLanes(randomWord(), MODE_FP32), MODE_FP32);
        end
        repeat (PHASE_LEN) driveCycle(randomWord(), randomWord(), idleMode());

        // new mode every cycle
        repeat (PHASE_LEN) begin
            mode = randomMode();
            a    = randomWord();
            b    = randomWord();
            if ($urandom_range(1) == 0) begin
                a = zeroLanes(a, mode);
            end
            if ($urandom_range(1) == 0) begin
                b = zeroLanes(b, mode);
            end
            driveCycle(a, b, mode);
        end

        driveCycle('0, '0, MODE_OFF);  // let the last item reach the checks
        repeat (2) @(posedge clk);
        #1;
        $display("Summary: %0d cycles checked, %0d errors", checkedCycles, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/fpMulPrepTop.sv ====
`default_nettype none

module fpMulPrepTop (
    input  wire logic                                   clk,
    input  wire logic                                   rstn,
    input  wire logic [fpPrepPkg::OPERAND_W-1:0]        i_a,
    input  wire logic [fpPrepPkg::OPERAND_W-1:0]        i_b,
    input  wire fpPrepPkg::precMode_t                   i_mode,
    output logic [fpPrepPkg::LANES-1:0]                 o_sign,
    output fpPrepPkg::expSum_t  [fpPrepPkg::LANES-1:0]  o_exp,
    output fpPrepPkg::manTile_t [fpPrepPkg::LANES-1:0]  o_manA,
    output fpPrepPkg::manTile_t [fpPrepPkg::LANES-1:0]  o_manB,
    output fpPrepPkg::precMode_t                        o_mode
);
    import fpPrepPkg::*;

    laneFieldsIf fieldsA ();
    laneFieldsIf fieldsB ();

    // a side tiles in hi,hi,lo,lo order
    operandUnpack #(
        .TileOrder (TILE_HHLL)
    ) unpackA (
        .i_word (i_a),
        .i_mode (i_mode),
        .fields (fieldsA.src)
    );

    // b side tiles in hi,lo,hi,lo order
    operandUnpack #(
        .TileOrder (TILE_HLHL)
    ) unpackB (
        .i_word (i_b),
        .i_mode (i_mode),
        .fields (fieldsB.src)
    );

    productPrepStage prepStage (
        .clk    (clk),
        .rstn   (rstn),
        .i_mode (i_mode),
        .a      (fieldsA.dst),
        .b      (fieldsB.dst),
        .o_sign (o_sign),
        .o_exp  (o_exp),
        .o_manA (o_manA),
        .o_manB (o_manB),
        .o_mode (o_mode)
    );

endmodule

`default_nettype wire

// ==== source/fpPrepPkg.sv ====
`default_nettype none

package fpPrepPkg;

    // operating mode, code 2 is reserved and acts like set-zero
    typedef enum logic [1:0] {
        MODE_FP16 = 2'b00,
        MODE_FP32 = 2'b01,
        MODE_RSVD = 2'b10,
        MODE_OFF  = 2'b11
    } precMode_t;

    // mantissa tile placement across the four lanes of an FP32 group
    typedef enum logic {
        TILE_HHLL = 1'b0,  // a side: hi,hi,lo,lo
        TILE_HLHL = 1'b1   // b side: hi,lo,hi,lo
    } tileOrder_t;

    // array geometry
    localparam int LANES       = 16;  // product lanes
    localparam int GROUP_LANES = 4;   // lanes per fp32 product
    localparam int OPERAND_W   = 256;

    // half precision layout
    localparam int FP16_W      = 16;
    localparam int FP16_EXP_W  = 5;
    localparam int FP16_FRAC_W = 10;

    // single precision layout
    localparam int FP32_W      = 32;
    localparam int FP32_EXP_W  = 8;
    localparam int FP32_FRAC_W = 23;

    // tile widths of the 13x13 partial product array
    localparam int TILE_W    = 13;
    localparam int TILE_LO_W = 13;  // low fp32 fraction bits

    typedef logic [7:0]        expField_t;  // raw exponent, zero-extended
    typedef logic [9:0]        expSum_t;    // exponent sum incl. tile offset
    typedef logic [TILE_W-1:0] manTile_t;

    // Exponent weight of each lane inside an FP32 group. Lane 0 multiplies
    // hi x hi (2^26), lanes 1 and 2 the cross terms, lane 3 lo x lo.
    localparam expSum_t FP32_LANE_OFFSET [GROUP_LANES] = '{
        10'd26,
        10'd13,
        10'd13,
        10'd0
    };

endpackage

`default_nettype wire

// ==== source/laneFieldsIf.sv ====
`default_nettype none

// one operand's per-lane fields after unpacking
interface laneFieldsIf;
    import fpPrepPkg::*;

    logic      [LANES-1:0] sign;  // sign bit per lane
    expField_t [LANES-1:0] exp;   // raw exponent field per lane
    logic      [LANES-1:0] zero;  // operand is zero in this lane
    manTile_t  [LANES-1:0] tile;  // mantissa tile fed to the array

    // unpacker side
    modport src (
        output sign,
        output exp,
        output zero,
        output tile
    );

    // register stage side
    modport dst (
        input sign,
        input exp,
        input zero,
        input tile
    );

endinterface

`default_nettype wire

// ==== source/operandUnpack.sv ====
`default_nettype none

module operandUnpack #(
    parameter fpPrepPkg::tileOrder_t TileOrder = fpPrepPkg::TILE_HHLL
) (
    input  wire logic [fpPrepPkg::OPERAND_W-1:0] i_word,
    input  wire fpPrepPkg::precMode_t            i_mode,
    laneFieldsIf.src                             fields
);
    import fpPrepPkg::*;

    localparam int HiFracW = FP32_FRAC_W - TILE_LO_W;       // 10 fraction bits in hi tile
    localparam int HiPadW  = TILE_W - 1 - HiFracW;          // leading zeros of hi tile
    localparam int HalfPadW = TILE_W - 1 - FP16_FRAC_W;     // leading zeros of fp16 tile

    for (genvar lane = 0; lane < LANES; lane++) begin : gLane
        localparam int Grp = lane / GROUP_LANES;            // fp32 word feeding this lane
        localparam int Pos = lane % GROUP_LANES;            // position inside the group
        // hi or lo tile per side of the array
        localparam bit UseHi = (TileOrder == TILE_HHLL) ? (Pos < 2) : ((Pos % 2) == 0);

        logic [FP16_W-1:0]    halfWord;
        logic [FP32_W-1:0]    singleWord;
        logic                 hid16;
        logic                 hid32;
        logic                 zero16;
        logic                 zero32;
        manTile_t             tile16;
        manTile_t             tileHi;
        manTile_t             tileLo;

        logic                 laneSign;
        expField_t            laneExp;
        logic                 laneZero;
        manTile_t             laneTile;

        assign halfWord   = i_word[lane*FP16_W +: FP16_W];
        assign singleWord = i_word[Grp*FP32_W +: FP32_W];  // low 128 bits only

        // implicit leading one for any nonzero exponent
        assign hid16 = |halfWord[FP16_W-2 -: FP16_EXP_W];
        assign hid32 = |singleWord[FP32_W-2 -: FP32_EXP_W];

        // zero when hidden bit and fraction are all clear
        assign zero16 = ~hid16 && (halfWord[FP16_FRAC_W-1:0] == '0);
        assign zero32 = ~hid32 && (singleWord[FP32_FRAC_W-1:0] == '0);

        assign tile16 = {{HalfPadW{1'b0}}, hid16, halfWord[FP16_FRAC_W-1:0]};
        assign tileHi = {{HiPadW{1'b0}}, hid32, singleWord[FP32_FRAC_W-1:TILE_LO_W]};
        assign tileLo = singleWord[TILE_LO_W-1:0];

        always_comb begin
            case (i_mode)
                MODE_FP16: begin
                    laneSign = halfWord[FP16_W-1];
                    laneExp  = expField_t'(halfWord[FP16_W-2 -: FP16_EXP_W]);
                    laneZero = zero16;
                    laneTile = tile16;
                end
                MODE_FP32: begin
                    // sign, exponent and zero shared by the whole group
                    laneSign = singleWord[FP32_W-1];
                    laneExp  = expField_t'(singleWord[FP32_W-2 -: FP32_EXP_W]);
                    laneZero = zero32;
                    laneTile = UseHi ? tileHi : tileLo;
                end
                default: begin  // off and reserved
                    laneSign = 1'b0;
                    laneExp  = '0;
                    laneZero = 1'b1;
                    laneTile = '0;
                end
            endcase
        end

        assign fields.sign[lane] = laneSign;
        assign fields.exp[lane]  = laneExp;
        assign fields.zero[lane] = laneZero;
        assign fields.tile[lane] = laneTile;
    end

endmodule

`default_nettype wire

// ==== source/productPrepStage.sv ====
`default_nettype none

module productPrepStage (
    input  wire logic                                   clk,
    input  wire logic                                   rstn,
    input  wire fpPrepPkg::precMode_t                   i_mode,
    laneFieldsIf.dst                                    a,
    laneFieldsIf.dst                                    b,
    output logic [fpPrepPkg::LANES-1:0]                 o_sign,
    output fpPrepPkg::expSum_t  [fpPrepPkg::LANES-1:0]  o_exp,
    output fpPrepPkg::manTile_t [fpPrepPkg::LANES-1:0]  o_manA,
    output fpPrepPkg::manTile_t [fpPrepPkg::LANES-1:0]  o_manB,
    output fpPrepPkg::precMode_t                        o_mode
);
    import fpPrepPkg::*;

    logic    [LANES-1:0] anyZero;   // either operand zero in the lane
    logic    [LANES-1:0] signNext;
    expSum_t [LANES-1:0] expNext;
    logic                addOffset;  // fp32 lanes carry tile weight

    assign anyZero   = a.zero | b.zero;
    assign signNext  = ~anyZero & (a.sign ^ b.sign);
    assign addOffset = (i_mode == MODE_FP32);

    // exponent sum, forced to zero for a zero product
    always_comb begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (anyZero[lane]) begin
                expNext[lane] = '0;
            end else if (addOffset) begin
                expNext[lane] = expSum_t'(a.exp[lane]) + expSum_t'(b.exp[lane])
                              + FP32_LANE_OFFSET[lane % GROUP_LANES];
            end else begin
                expNext[lane] = expSum_t'(a.exp[lane]) + expSum_t'(b.exp[lane]);
            end
        end
    end

    // sign and exponent
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_sign <= '0;
            o_exp  <= '0;
        end else begin
            o_sign <= signNext;
            o_exp  <= expNext;
        end
    end

    // mantissa tiles go through as unpacked
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_manA <= '0;
            o_manB <= '0;
        end else begin
            o_manA <= a.tile;
            o_manB <= b.tile;
        end
    end

    // mode travels with its data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_mode <= MODE_OFF;
        end else begin
            o_mode <= i_mode;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
source/fpPrepPkg.sv
source/laneFieldsIf.sv
source/operandUnpack.sv
source/productPrepStage.sv
source/fpMulPrepTop.sv
dv/fpPrepTb.sv
